/* build.f */
+incdir+include
source/alphabetPkg.sv
source/rotorPkg.sv
source/pipeCtrlIf.sv
source/stepControl.sv
source/letterCodec.sv
source/rotorStage.sv
source/scrambler.sv
source/enigmaTop.sv
tb/enigmaTb.sv

/* Makefile */
# Verilator build and run of the Enigma cipher testbench

VERILATOR ?= verilator
TOP       ?= enigmaTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the testbench output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/enigmaTb.sv */
// Testbench for the Enigma cipher top level: table-driven messages checked against a software model
`timescale 1ns/1ns

module enigmaTb import alphabetPkg::*, rotorPkg::*;;

    localparam int entryCount     = 5;
    localparam int resetCycles    = 4;
    localparam int handshakeLimit = 200;
    localparam int drainLimit     = 200;

    // Start positions are rotor 1, rotor 2, rotor 3
    localparam int startTable [entryCount][rotorCount] = '{
        '{ 0,  0,  0},
        '{14,  0,  0},
        '{12,  4,  9},
        '{20, 25, 25},
        '{16,  4, 25}
    };

    string messageTable [entryCount] = '{
        "ENIGMAMACHINE",
        "ATTACKATDAWN",
        "WEATHERREPORTNORTHSEA",
        "THEQUICKBROWNFOXJUMPSOVERTHELAZYDOG",
        "KEEPTHELINESOPEN"
    };

    logic     load;
    logic     arstN;
    asciiT    inChar;
    logic     inValid;
    logic     inReady;
    positionT startPos1;
    positionT startPos2;
    positionT startPos3;
    logic     setPositions;
    asciiT    outChar;
    logic     outValid;
    logic     outReady;

    integer      seed = 75;
    logic [31:0] randomWord;
    logic        randomReady = 1'b0;
    logic        outBusy = 1'b0;
    int          edgeNum = 0;
    int          mismatchCount = 0;
    int          otherCount = 0;
    int          modelPos [rotorCount];

    asciiT sendQ [$];
    asciiT expQ [$];
    asciiT gotQ [$];
    asciiT plainQ [$];
    asciiT cipherQ [$];
    int    acceptEdges [$];
    int    outEdges [$];

    enigmaTop dut_i (
        .load         (load),
        .arstN        (arstN),
        .inChar       (inChar),
        .inValid      (inValid),
        .inReady      (inReady),
        .startPos1    (startPos1),
        .startPos2    (startPos2),
        .startPos3    (startPos3),
        .setPositions (setPositions),
        .outChar      (outChar),
        .outValid     (outValid),
        .outReady     (outReady)
    );

    always #50 load = ~load;

    always @(posedge load) begin
        edgeNum <= edgeNum + 1;
    end

    // Ready pattern for the back-pressure pass
    always @(posedge load) begin
        if (randomReady) begin
            randomWord = $random(seed);
            outReady <= (randomWord[1:0] != 2'b00);
        end else begin
            outReady <= 1'b1;
        end
    end

    // Transfers are decided by values that settle before the falling edge
    always @(negedge load) begin
        if (arstN) begin
            if (inValid && inReady) begin
                acceptEdges.push_back(edgeNum + 1);
            end
            if (outValid && outReady) begin
                outEdges.push_back(edgeNum + 1);
                gotQ.push_back(outChar);
            end
            if (outValid && !outReady) begin
                compareValue("inReady", 32'(inReady), 32'd0);
            end
            outBusy = outValid;
        end
    end

    task compareValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("FAIL time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task reportAndFinish;
        $display("Errors: %0d value mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task abortOnTimeout(string what);
        otherCount++;
        $display("ERROR at %0t: timeout, %s", $time, what);
        reportAndFinish();
    endtask

    // Plugboard output contact i is fed from contact plugPairs[i]
    function automatic int plugMap(int c);
        int result;
        result = 0;
        for (int i = 0; i < letterCount; i++) begin
            if (int'(plugPairs[i]) == c) begin
                result = i;
            end
        end
        return result;
    endfunction

    function automatic int reflectMap(int c);
        int result;
        result = 0;
        for (int i = 0; i < letterCount; i++) begin
            if (int'(reflectorWiring[i]) == c) begin
                result = i;
            end
        end
        return result;
    endfunction

    function automatic int rotorForward(int r, int c, int pos);
        int entered;
        int wired;
        entered = (c + pos) % letterCount;
        wired = 0;
        for (int i = 0; i < letterCount; i++) begin
            if (int'(rotorWiring[r][i]) == entered) begin
                wired = i;
            end
        end
        return (wired - pos + letterCount) % letterCount;
    endfunction

    function automatic int rotorBackward(int r, int c, int pos);
        int entered;
        entered = (c + pos) % letterCount;
        return (int'(rotorWiring[r][entered]) - pos + letterCount) % letterCount;
    endfunction

    function automatic asciiT encipherLetter(asciiT ch, int pos1, int pos2, int pos3);
        int pos [rotorCount];
        int c;
        pos[0] = pos1;
        pos[1] = pos2;
        pos[2] = pos3;
        c = plugMap(int'(ch) - int'(letterBase));
        for (int r = 0; r < rotorCount; r++) begin
            c = rotorForward(r, c, pos[r]);
        end
        c = reflectMap(c);
        for (int r = rotorCount - 1; r >= 0; r--) begin
            c = rotorBackward(r, c, pos[r]);
        end
        c = plugMap(c);
        return asciiT'(c + int'(letterBase));
    endfunction

    // Odometer carries use the positions from before the step
    task stepModel;
        logic carry2;
        logic carry3;
        carry2 = (modelPos[0] == int'(notchPos[0]));
        carry3 = carry2 && (modelPos[1] == int'(notchPos[1]));
        modelPos[0] = (modelPos[0] + 1) % letterCount;
        if (carry2) begin
            modelPos[1] = (modelPos[1] + 1) % letterCount;
        end
        if (carry3) begin
            modelPos[2] = (modelPos[2] + 1) % letterCount;
        end
    endtask

    task loadPositions(int pos1, int pos2, int pos3);
        startPos1    <= positionT'(pos1);
        startPos2    <= positionT'(pos2);
        startPos3    <= positionT'(pos3);
        setPositions <= 1'b1;
        @(negedge load);
        compareValue("inReady", 32'(inReady), 32'd0);
        @(posedge load);
        setPositions <= 1'b0;
        modelPos[0] = pos1;
        modelPos[1] = pos2;
        modelPos[2] = pos3;
    endtask

    task loadMessage(string msg);
        sendQ.delete();
        for (int i = 0; i < msg.len(); i++) begin
            sendQ.push_back(asciiT'(msg[i]));
        end
    endtask

    task sendLetters;
        int waited;
        for (int i = 0; i < sendQ.size(); i++) begin
            inChar  <= sendQ[i];
            inValid <= 1'b1;
            waited = 0;
            @(negedge load);
            while (!inReady) begin
                if (waited == handshakeLimit) begin
                    abortOnTimeout("inReady stayed low while a letter was waiting");
                end
                waited++;
                @(negedge load);
            end
            @(posedge load);
        end
        inValid <= 1'b0;
    endtask

    task waitForOutputs(int count);
        int waited;
        waited = 0;
        while (gotQ.size() < count || outBusy) begin
            if (waited == drainLimit) begin
                abortOnTimeout("the output did not deliver every letter");
            end
            waited++;
            @(posedge load);
        end
    endtask

    task runLetters(bit timingChecks);
        gotQ.delete();
        acceptEdges.delete();
        outEdges.delete();
        expQ.delete();
        for (int i = 0; i < sendQ.size(); i++) begin
            stepModel();
            expQ.push_back(encipherLetter(sendQ[i], modelPos[0], modelPos[1], modelPos[2]));
        end
        sendLetters();
        waitForOutputs(sendQ.size());
        compareValue("output count", 32'(gotQ.size()), 32'(sendQ.size()));
        for (int i = 0; i < sendQ.size(); i++) begin
            compareValue("outChar", 32'(gotQ[i]), 32'(expQ[i]));
            if (gotQ[i] == sendQ[i]) begin
                otherCount++;
                $display("ERROR at %0t: letter %0d (%c) was enciphered to itself",
                         $time, i, sendQ[i]);
            end
            if (timingChecks) begin
                compareValue("latency", 32'(outEdges[i] - acceptEdges[i]), 32'd2);
                if (i > 0) begin
                    compareValue("accept spacing", 32'(acceptEdges[i] - acceptEdges[i-1]),
                                 32'd1);
                end
            end
        end
    endtask

    // Encipher each entry, then reload and decipher the result
    task runTable(bit timingChecks);
        for (int e = 0; e < entryCount; e++) begin
            loadPositions(startTable[e][0], startTable[e][1], startTable[e][2]);
            loadMessage(messageTable[e]);
            plainQ = sendQ;
            runLetters(timingChecks);
            cipherQ = gotQ;
            loadPositions(startTable[e][0], startTable[e][1], startTable[e][2]);
            sendQ = cipherQ;
            runLetters(timingChecks);
            for (int i = 0; i < plainQ.size(); i++) begin
                compareValue("deciphered outChar", 32'(gotQ[i]), 32'(plainQ[i]));
            end
        end
    endtask

    initial begin
        load          = 1'b0;
        arstN        <= 1'b0;
        inChar       <= letterBase;
        inValid      <= 1'b0;
        startPos1    <= '0;
        startPos2    <= '0;
        startPos3    <= '0;
        setPositions <= 1'b0;
        outReady     <= 1'b1;
        for (int r = 0; r < rotorCount; r++) begin
            modelPos[r] = 0;
        end
        repeat (resetCycles) @(posedge load);
        arstN <= 1'b1;
        @(negedge load);
        compareValue("outValid", 32'(outValid), 32'd0);
        compareValue("inReady", 32'(inReady), 32'd1);
        @(posedge load);

        // Positions straight from reset
        loadMessage("NOSTARTPOSITIONSLOADED");
        runLetters(1'b1);

        runTable(1'b1);
        randomReady <= 1'b1;
        runTable(1'b0);
        reportAndFinish();
    end

endmodule

/* source/enigmaTop.sv */
// Enigma cipher top level: valid/ready ASCII letters in, enciphered letters out two cycles on
`timescale 1ns/1ns

module enigmaTop import alphabetPkg::*, rotorPkg::*; (
    input  logic     load,
    input  logic     arstN,
    input  asciiT    inChar,
    input  logic     inValid,
    output logic     inReady,
    input  positionT startPos1,
    input  positionT startPos2,
    input  positionT startPos3,
    input  logic     setPositions,
    output asciiT    outChar,
    output logic     outValid,
    input  logic     outReady
);

    oneHotT plugIn;
    oneHotT plugBack;

    pipeCtrlIf pipe ();

    stepControl stepControl_i (
        .load         (load),
        .arstN        (arstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .setPositions (setPositions),
        .startPos1    (startPos1),
        .startPos2    (startPos2),
        .startPos3    (startPos3),
        .outValid     (outValid),
        .outReady     (outReady),
        .pipe         (pipe)
    );

    letterCodec letterCodec_i (
        .load     (load),
        .arstN    (arstN),
        .inChar   (inChar),
        .inValid  (inValid),
        .plugIn   (plugIn),
        .plugBack (plugBack),
        .outChar  (outChar),
        .pipe     (pipe)
    );

    scrambler scrambler_i (
        .load     (load),
        .arstN    (arstN),
        .plugIn   (plugIn),
        .plugBack (plugBack),
        .pipe     (pipe)
    );

endmodule

/* source/scrambler.sv */
// Rotor chain and reflector between the plugboard paths, with the first pipeline register
`timescale 1ns/1ns

module scrambler import alphabetPkg::*, rotorPkg::*; (
    input  logic        load,
    input  logic        arstN,
    input  oneHotT      plugIn,
    output oneHotT      plugBack,
    pipeCtrlIf.datapath pipe
);

    // fwd[r] and back[r] are the contacts on the plugboard side of rotor r
    oneHotT fwd  [rotorCount+1];
    oneHotT back [rotorCount+1];
    oneHotT reflected;

    assign fwd[0] = plugIn;

    for (genvar r = 0; r < rotorCount; r++) begin : gRotor
        rotorStage #(
            .rotorIndex (r)
        ) rotor_i (
            .fwdIn    (fwd[r]),
            .fwdOut   (fwd[r+1]),
            .backIn   (back[r+1]),
            .backOut  (back[r]),
            .position (pipe.positions[r])
        );
    end

    always_comb begin
        for (int i = 0; i < letterCount; i++) begin
            reflected[i] = fwd[rotorCount][reflectorWiring[i]];
        end
    end

    assign back[rotorCount] = reflected;

    // Stage 1 takes a letter only on its accept cycle
    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            plugBack <= oneHotT'(1);
        end else if (pipe.accept) begin
            plugBack <= back[0];
        end
    end

endmodule

/* source/rotorStage.sv */
// One rotor at a given offset, mapping a letter forward toward the reflector and back again
`timescale 1ns/1ns

module rotorStage import alphabetPkg::*, rotorPkg::*; #(
    parameter int rotorIndex = 0
) (
    input  oneHotT   fwdIn,
    output oneHotT   fwdOut,
    input  oneHotT   backIn,
    output oneHotT   backOut,
    input  positionT position
);

    oneHotT fwdEntered;
    oneHotT fwdWired;
    oneHotT backEntered;
    oneHotT backWired;

    function automatic oneHotT rotL(oneHotT word, positionT amount);
        return (word << amount) | (word >> (letterCount - amount));
    endfunction

    function automatic oneHotT rotR(oneHotT word, positionT amount);
        return (word >> amount) | (word << (letterCount - amount));
    endfunction

    // Contact c meets rotor pin c+position, the exit pin is turned back by the same offset
    always_comb begin
        fwdEntered = rotL(fwdIn, position);
        for (int i = 0; i < letterCount; i++) begin
            fwdWired[i] = fwdEntered[rotorWiring[rotorIndex][i]];
        end
        fwdOut = rotR(fwdWired, position);
    end

    // Same table read the other way round
    always_comb begin
        backEntered = rotL(backIn, position);
        backWired   = '0;
        for (int i = 0; i < letterCount; i++) begin
            backWired[rotorWiring[rotorIndex][i]] = backEntered[i];
        end
        backOut = rotR(backWired, position);
    end

endmodule

/* source/letterCodec.sv */
// ASCII to one-hot decode and plugboard on the way in, plugboard and ASCII encode on the way out
`timescale 1ns/1ns

module letterCodec import alphabetPkg::*, rotorPkg::*; (
    input  logic        load,
    input  logic        arstN,
    input  asciiT       inChar,
    input  logic        inValid,
    output oneHotT      plugIn,
    input  oneHotT      plugBack,
    output asciiT       outChar,
    pipeCtrlIf.datapath pipe
);

    // The plugboard is an involution, so one swap serves both directions
    function automatic oneHotT plugSwap(oneHotT word);
        oneHotT swapped;
        for (int i = 0; i < letterCount; i++) begin
            swapped[i] = word[plugPairs[i]];
        end
        return swapped;
    endfunction

    assign plugIn = plugSwap(toOneHot(inChar));

    always_ff @(posedge load) begin
        if (pipe.advance) begin
            outChar <= toAscii(plugSwap(plugBack));
        end
    end

    inCharRange: assert property (@(posedge load) disable iff (!arstN)
        inValid |-> (inChar >= letterBase && inChar <= letterLast))
        else $error("inChar 0x%02h is not an uppercase letter", inChar);

    // Catches a broken permutation anywhere in the rotors or reflector
    returnOneHot: assert property (@(posedge load) disable iff (!arstN)
        $onehot(plugBack))
        else $error("scrambler returned 0x%07h, not a single letter", plugBack);

endmodule

/* source/stepControl.sv */
// Valid/ready flow control, start position loading and odometer stepping of the three rotors
`timescale 1ns/1ns

module stepControl import rotorPkg::*; (
    input  logic     load,
    input  logic     arstN,
    input  logic     inValid,
    output logic     inReady,
    input  logic     setPositions,
    input  positionT startPos1,
    input  positionT startPos2,
    input  positionT startPos3,
    output logic     outValid,
    input  logic     outReady,
    pipeCtrlIf.ctrl  pipe
);

    positionsT             posReg;
    positionsT             stepped;
    positionsT             startPos;
    logic [rotorCount-1:0] carry;
    logic                  stage1Valid;

    assign startPos = {startPos3, startPos2, startPos1};

    // Rotor 1 always moves, the others on a notch carry
    always_comb begin
        carry[0] = 1'b1;
        for (int r = 1; r < rotorCount; r++) begin
            carry[r] = carry[r-1] && (posReg[r-1] == notchPos[r-1]);
        end
        for (int r = 0; r < rotorCount; r++) begin
            if (!carry[r]) begin
                stepped[r] = posReg[r];
            end else if (posReg[r] == lastPos) begin
                stepped[r] = '0;
            end else begin
                stepped[r] = posReg[r] + 1'b1;
            end
        end
    end

    // A waiting output letter freezes both stages
    assign pipe.advance   = !(outValid && !outReady);
    assign inReady        = pipe.advance && !setPositions;
    assign pipe.accept    = inValid && inReady;
    assign pipe.positions = stepped;
    assign pipe.setNow    = setPositions;

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            posReg      <= '0;
            stage1Valid <= 1'b0;
            outValid    <= 1'b0;
        end else begin
            if (setPositions) begin
                posReg <= startPos;
            end else if (pipe.accept) begin
                posReg <= stepped;
            end
            if (pipe.advance) begin
                stage1Valid <= pipe.accept;
                outValid    <= stage1Valid;
            end
        end
    end

    for (genvar r = 0; r < rotorCount; r++) begin : gRange
        positionRange: assert property (@(posedge load) disable iff (!arstN)
            posReg[r] <= lastPos)
            else $error("rotor %0d position %0d out of range", r + 1, posReg[r]);
    end

    loadNotAccept: assert property (@(posedge load) disable iff (!arstN)
        pipe.setNow |-> !pipe.accept)
        else $error("start position load collides with an accepted letter");

endmodule

/* source/pipeCtrlIf.sv */
// Pipeline advance, accept and stepped rotor positions passed from flow control to the datapath
`timescale 1ns/1ns

interface pipeCtrlIf import rotorPkg::*; ();

    logic      advance;
    positionsT positions;
    logic      accept;
    logic      setNow;

    modport ctrl (
        output advance,
        output positions,
        output accept,
        output setNow
    );

    // Datapath registers only follow the flow, they never steer it
    modport datapath (
        input advance,
        input positions,
        input accept
    );

endinterface

/* source/rotorPkg.sv */
// Rotor positions, stepping constants, wiring tables and control states for the cipher
package rotorPkg;
    import alphabetPkg::*;

    localparam int rotorCount = 3;

    // Offset of one rotor, 0 to 25
    typedef logic [4:0] positionT;

    // Index 0 is rotor 1, the fast one
    typedef positionT [rotorCount-1:0] positionsT;

    localparam positionT lastPos = positionT'(letterCount - 1);

    // Leaving Q on rotor 1 or E on rotor 2 carries into the next rotor
    localparam positionT notchPos [rotorCount] = '{16, 4, 0};

    `include "enigmaWiring.svh"

    typedef enum logic {
        idle,
        stalled
    } ctrlStateT;

endpackage

/* source/alphabetPkg.sv */
// Letter encoding types and ASCII/one-hot conversions shared by the cipher and its testbench
package alphabetPkg;

    localparam int letterCount = 26;

    typedef logic [7:0] asciiT;

    // One bit per letter, bit 0 is A
    typedef logic [letterCount-1:0] oneHotT;

    localparam asciiT letterBase = 8'h41;
    localparam asciiT letterLast = asciiT'(letterBase + letterCount - 1);

    // Characters outside A-Z give an all-zero word
    function automatic oneHotT toOneHot(asciiT code);
        return oneHotT'(1) << (code - letterBase);
    endfunction

    function automatic asciiT toAscii(oneHotT word);
        asciiT code;
        code = letterBase;
        for (int i = 0; i < letterCount; i++) begin
            if (word[i]) begin
                code = letterBase + asciiT'(i);
            end
        end
        return code;
    endfunction

endpackage

/* include/enigmaWiring.svh */
// Rotor, reflector and plugboard wiring tables, pulled into the rotor package by include
`ifndef ENIGMA_WIRING_SVH
`define ENIGMA_WIRING_SVH

// Forward path: output contact i is fed from input contact rotorWiring[r][i]
localparam positionT rotorWiring [rotorCount][letterCount] = '{
    '{ 7, 12, 21, 17,  0,  2, 22, 20, 23, 18,  9, 25, 15,
       3, 14, 13, 11,  8,  4, 10,  6,  5, 19, 16, 24,  1},
    '{19,  4,  7,  6, 12, 17,  8,  5,  2,  0,  1, 20, 25,
       9, 14, 22, 24, 18, 15, 13,  3, 10, 21, 16, 11, 23},
    '{19,  0,  6,  1, 15,  2, 18,  3, 16,  4, 20,  5, 21,
      13, 25,  7, 24,  8, 23,  9, 22, 11, 17, 10, 14, 12}
};

// Reflector pairs, every letter maps to a different one
localparam positionT reflectorWiring [letterCount] = '{
    24, 17, 20,  7, 16, 18, 11,  3, 15, 23, 13,  6, 14,
    10, 12,  8,  4,  1,  5, 25,  2, 22, 21,  9,  0, 19
};

// Plugboard swaps A-M, C-X, F-R, H-T, J-Y and O-V
localparam positionT plugPairs [letterCount] = '{
    12,  1, 23,  3,  4, 17,  6, 19,  8, 24, 10, 11,  0,
    13, 21, 15, 16,  5, 18,  7, 20, 14, 22,  2,  9, 25
};

`endif
